/* src/zebra_consts.svh */
`ifndef ZEBRA_CONSTS_SVH
`define ZEBRA_CONSTS_SVH

// Frame geometry in pixels
`define ZC_IMG_WIDTH 32
`define ZC_IMG_HEIGHT 24

// Margin kept out of the scan and of outline following
`define ZC_BORDER 2

// Smallest closed outline that still counts as a stripe
`define ZC_MIN_EDGE_LENGTH 12

// Stripes needed before a crossing is reported
`define ZC_MIN_STRIPES 3

`endif

/* src/img_pkg.sv */
`default_nettype none

`include "zebra_consts.svh"

package img_pkg;

    // Column index, one bit wider than needed is never required
    // since the margin keeps neighbours inside the frame
    typedef logic [$clog2(`ZC_IMG_WIDTH)-1:0] coord_x_t;

    // Row index
    typedef logic [$clog2(`ZC_IMG_HEIGHT)-1:0] coord_y_t;

    // Raster address, row * width + column
    typedef logic [$clog2(`ZC_IMG_WIDTH*`ZC_IMG_HEIGHT)-1:0] pix_addr_t;

endpackage

`default_nettype wire

/* src/detect_pkg.sv */
`default_nettype none

package detect_pkg;

    // Tracer FSM
    typedef enum logic [2:0] {
        st_idle,
        st_wait_read,
        st_scan,
        st_check_neighbor,
        st_follow_edge,
        st_finish
    } trace_state_t;

    typedef logic [15:0] contour_len_t;
    typedef logic [7:0] stripe_count_t;

    // One report per traced outline
    typedef struct packed {
        logic closed;
        contour_len_t length;
    } contour_report_t;

    // Frame verdict
    typedef struct packed {
        logic crossing;
        stripe_count_t stripes;
    } detect_result_t;

endpackage

`default_nettype wire

/* src/edge_frame_buffer.sv */
`default_nettype none

`include "zebra_consts.svh"

module edge_frame_buffer (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              pix_valid,
    input  wire logic              pix_bit,
    input  wire logic              frame_start,
    input  wire logic              trace_busy,
    input  wire img_pkg::pix_addr_t rd_addr,
    output logic                   rd_bit,
    output logic                   frame_ready
);

    localparam int npix = `ZC_IMG_WIDTH * `ZC_IMG_HEIGHT;
    localparam img_pkg::pix_addr_t last_addr = img_pkg::pix_addr_t'(npix - 1);

    logic mem [npix];

    img_pkg::pix_addr_t wr_addr;
    img_pkg::pix_addr_t wr_ptr;
    logic filling;
    logic blocked;
    logic wr_en;

    // No writes while the tracer owns the memory
    assign blocked = trace_busy || frame_ready;
    assign wr_ptr  = frame_start ? '0 : wr_addr;
    assign wr_en   = pix_valid && !blocked && (frame_start || filling);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr     <= '0;
            filling     <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= wr_en && (wr_ptr == last_addr);
            if (pix_valid && blocked) begin
                // A frame overlapping a trace is dropped as a whole
                filling <= 1'b0;
            end else if (wr_en) begin
                filling <= (wr_ptr != last_addr);
                wr_addr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= pix_bit;
        end
        rd_bit <= mem[rd_addr];
    end

    // Completion can only come from a write accepted while the tracer idled
    a_ready_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n) !(frame_ready && trace_busy)
    ) else $error("frame_ready raised while the tracer is busy");

endmodule

`default_nettype wire

/* src/contour_tracer.sv */
`default_nettype none

`include "zebra_consts.svh"

module contour_tracer (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     frame_ready,
    output img_pkg::pix_addr_t            rd_addr,
    input  wire logic                     rd_bit,
    output logic                          trace_busy,
    output logic                          contour_valid,
    output logic                          scan_done,
    output detect_pkg::contour_report_t   contour
);

    localparam int img_w = `ZC_IMG_WIDTH;
    localparam int npix  = `ZC_IMG_WIDTH * `ZC_IMG_HEIGHT;
    localparam int x_lo  = `ZC_BORDER;
    localparam int x_hi  = `ZC_IMG_WIDTH - `ZC_BORDER - 1;
    localparam int y_lo  = `ZC_BORDER;
    localparam int y_hi  = `ZC_IMG_HEIGHT - `ZC_BORDER - 1;

    // Neighbour offsets biased by one: 0 is -1, 1 is 0, 2 is +1
    // Orthogonal neighbours come first so corners are never cut diagonally
    // Order is N, W, E, S, NW, NE, SW, SE
    localparam logic [1:0] nbr_dx [8] = '{2'd1, 2'd0, 2'd2, 2'd1, 2'd0, 2'd2, 2'd0, 2'd2};
    localparam logic [1:0] nbr_dy [8] = '{2'd0, 2'd1, 2'd1, 2'd2, 2'd0, 2'd0, 2'd2, 2'd2};

    detect_pkg::trace_state_t state;

    // Scan position, kept while an outline is followed
    img_pkg::coord_x_t x_pos;
    img_pkg::coord_y_t y_pos;

    img_pkg::coord_x_t x_edge, x_start, x_prev, next_x, scan_nx;
    img_pkg::coord_y_t y_edge, y_start, y_prev, next_y, scan_ny;
    detect_pkg::contour_len_t edge_length;
    logic [3:0] nbr_idx;

    logic [npix-1:0] visited;

    img_pkg::pix_addr_t scan_addr;
    img_pkg::pix_addr_t next_addr;
    img_pkg::coord_x_t dx_abs;
    img_pkg::coord_y_t dy_abs;
    logic in_bounds;
    logic is_prev;
    logic scan_hit;
    logic step_ok;
    logic scan_last;
    logic near_start;

    function automatic img_pkg::pix_addr_t addr_of(img_pkg::coord_x_t x, img_pkg::coord_y_t y);
        return img_pkg::pix_addr_t'(y * img_w + x);
    endfunction

    always_comb begin
        next_x    = x_edge + nbr_dx[nbr_idx[2:0]] - 1'b1;
        next_y    = y_edge + nbr_dy[nbr_idx[2:0]] - 1'b1;
        in_bounds = (next_x >= x_lo) && (next_x <= x_hi) && (next_y >= y_lo) && (next_y <= y_hi);
        is_prev   = (next_x == x_prev) && (next_y == y_prev);
        next_addr = addr_of(next_x, next_y);
        scan_addr = addr_of(x_pos, y_pos);
        scan_hit  = (state == detect_pkg::st_scan) && rd_bit && !visited[scan_addr];
        step_ok   = (state == detect_pkg::st_follow_edge) && rd_bit &&
                    !visited[next_addr] && !is_prev;

        // Raster advance inside the margin
        scan_last = (x_pos == x_hi) && (y_pos == y_hi);
        scan_nx   = (x_pos == x_hi) ? img_pkg::coord_x_t'(x_lo) : x_pos + 1'b1;
        scan_ny   = (x_pos == x_hi) ? y_pos + 1'b1 : y_pos;

        dx_abs     = (x_edge > x_start) ? x_edge - x_start : x_start - x_edge;
        dy_abs     = (y_edge > y_start) ? y_edge - y_start : y_start - y_edge;
        near_start = (dx_abs <= 1) && (dy_abs <= 1);
    end

    // Neighbour read is issued from check_neighbor, data lands in follow_edge
    assign rd_addr    = (state == detect_pkg::st_check_neighbor) ? next_addr : scan_addr;
    assign trace_busy = (state != detect_pkg::st_idle);

    always_ff @(posedge clk) begin
        if (frame_ready) begin
            visited <= '0;
        end else if (scan_hit) begin
            visited[scan_addr] <= 1'b1;
        end else if (step_ok) begin
            visited[next_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= detect_pkg::st_idle;
            x_pos         <= img_pkg::coord_x_t'(x_lo);
            y_pos         <= img_pkg::coord_y_t'(y_lo);
            x_edge        <= '0;
            y_edge        <= '0;
            x_start       <= '0;
            y_start       <= '0;
            x_prev        <= '0;
            y_prev        <= '0;
            edge_length   <= '0;
            nbr_idx       <= '0;
            contour_valid <= 1'b0;
            scan_done     <= 1'b0;
            contour       <= '0;
        end else begin
            contour_valid <= 1'b0;
            scan_done     <= 1'b0;
            case (state)
                detect_pkg::st_idle: begin
                    if (frame_ready) begin
                        x_pos <= img_pkg::coord_x_t'(x_lo);
                        y_pos <= img_pkg::coord_y_t'(y_lo);
                        state <= detect_pkg::st_wait_read;
                    end
                end
                detect_pkg::st_wait_read: begin
                    state <= detect_pkg::st_scan;
                end
                detect_pkg::st_scan: begin
                    if (scan_hit) begin
                        x_start     <= x_pos;
                        y_start     <= y_pos;
                        x_edge      <= x_pos;
                        y_edge      <= y_pos;
                        x_prev      <= x_pos;
                        y_prev      <= y_pos;
                        edge_length <= 16'd1;
                        nbr_idx     <= '0;
                        state       <= detect_pkg::st_check_neighbor;
                    end else if (scan_last) begin
                        state <= detect_pkg::st_finish;
                    end else begin
                        x_pos <= scan_nx;
                        y_pos <= scan_ny;
                        state <= detect_pkg::st_wait_read;
                    end
                end
                detect_pkg::st_check_neighbor: begin
                    if (nbr_idx[3]) begin
                        // Outline ended, report and resume the raster
                        contour_valid  <= 1'b1;
                        contour.closed <= near_start && (edge_length > 16'd3);
                        contour.length <= edge_length;
                        if (scan_last) begin
                            state <= detect_pkg::st_finish;
                        end else begin
                            x_pos <= scan_nx;
                            y_pos <= scan_ny;
                            state <= detect_pkg::st_wait_read;
                        end
                    end else if (in_bounds) begin
                        state <= detect_pkg::st_follow_edge;
                    end else begin
                        nbr_idx <= nbr_idx + 1'b1;
                    end
                end
                detect_pkg::st_follow_edge: begin
                    if (step_ok) begin
                        x_prev      <= x_edge;
                        y_prev      <= y_edge;
                        x_edge      <= next_x;
                        y_edge      <= next_y;
                        edge_length <= edge_length + 1'b1;
                        nbr_idx     <= '0;
                    end else begin
                        nbr_idx <= nbr_idx + 1'b1;
                    end
                    state <= detect_pkg::st_check_neighbor;
                end
                detect_pkg::st_finish: begin
                    scan_done <= 1'b1;
                    state     <= detect_pkg::st_idle;
                end
                default: state <= detect_pkg::st_idle;
            endcase
        end
    end

    a_report_before_done: assert property (
        @(posedge clk) disable iff (!rst_n) !(contour_valid && scan_done)
    ) else $error("contour report collides with scan_done");

    a_addr_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n) rd_addr < img_pkg::pix_addr_t'(npix)
    ) else $error("read address outside the frame");

endmodule

`default_nettype wire

/* src/crossing_verdict.sv */
`default_nettype none

`include "zebra_consts.svh"

module crossing_verdict (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        frame_ready,
    input  wire logic                        contour_valid,
    input  wire detect_pkg::contour_report_t contour,
    input  wire logic                        scan_done,
    output logic                             result_valid,
    output detect_pkg::detect_result_t       result
);

    detect_pkg::stripe_count_t stripes;
    logic stripe_hit;

    // Only closed outlines of stripe size count
    assign stripe_hit = contour_valid && contour.closed &&
                        (contour.length >= `ZC_MIN_EDGE_LENGTH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stripes      <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= scan_done;
            if (frame_ready) begin
                stripes <= '0;
            end else if (stripe_hit && (stripes != '1)) begin
                stripes <= stripes + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_done) begin
            result.stripes  <= stripes;
            result.crossing <= (stripes >= `ZC_MIN_STRIPES);
        end
    end

    a_result_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) result_valid |=> !result_valid
    ) else $error("result_valid held longer than one cycle");

endmodule

`default_nettype wire

/* src/zebra_crossing_top.sv */
`default_nettype none

module zebra_crossing_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  pix_valid,
    input  wire logic                  pix_bit,
    input  wire logic                  frame_start,
    output logic                       result_valid,
    output detect_pkg::detect_result_t result
);

    img_pkg::pix_addr_t rd_addr;
    logic rd_bit;
    logic frame_ready;
    logic trace_busy;
    logic contour_valid;
    logic scan_done;
    detect_pkg::contour_report_t contour;

    // Pixel stream into bit memory
    edge_frame_buffer u_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_valid   (pix_valid),
        .pix_bit     (pix_bit),
        .frame_start (frame_start),
        .trace_busy  (trace_busy),
        .rd_addr     (rd_addr),
        .rd_bit      (rd_bit),
        .frame_ready (frame_ready)
    );

    contour_tracer u_tracer (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame_ready   (frame_ready),
        .rd_addr       (rd_addr),
        .rd_bit        (rd_bit),
        .trace_busy    (trace_busy),
        .contour_valid (contour_valid),
        .scan_done     (scan_done),
        .contour       (contour)
    );

    // Stripe count and crossing flag
    crossing_verdict u_verdict (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame_ready   (frame_ready),
        .contour_valid (contour_valid),
        .contour       (contour),
        .scan_done     (scan_done),
        .result_valid  (result_valid),
        .result        (result)
    );

endmodule

`default_nettype wire

/* test/tb_frame_patterns.svh */
`ifndef TB_FRAME_PATTERNS_SVH
`define TB_FRAME_PATTERNS_SVH

localparam int img_w = `ZC_IMG_WIDTH;
localparam int img_h = `ZC_IMG_HEIGHT;
localparam int lo    = `ZC_BORDER;
localparam int x_hi  = `ZC_IMG_WIDTH - `ZC_BORDER - 1;
localparam int y_hi  = `ZC_IMG_HEIGHT - `ZC_BORDER - 1;

logic [31:0] lcg_state = 32'h01b0e693;
logic img [img_h][img_w];
// Closed outlines of stripe size drawn so far
int good_rects;

function automatic int random_in_range(input int min_v, input int max_v);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return min_v + int'(lcg_state[30:8] % (max_v - min_v + 1));
endfunction

task automatic clear_image();
    foreach (img[r, c]) begin
        img[r][c] = 1'b0;
    end
    good_rects = 0;
endtask

// Keeps two black pixels between any two shapes
function automatic bit area_free(input int x, input int y, input int w, input int h);
    for (int r = y - 2; r <= y + h + 1; r++) begin
        for (int c = x - 2; c <= x + w + 1; c++) begin
            if (r >= 0 && r < img_h && c >= 0 && c < img_w && img[r][c]) begin
                return 1'b0;
            end
        end
    end
    return 1'b1;
endfunction

// Hollow, one pixel thick, outline length 2(w+h)-4
task automatic draw_rect(input int x, input int y, input int w, input int h);
    for (int i = 0; i < w; i++) begin
        img[y][x + i] = 1'b1;
        img[y + h - 1][x + i] = 1'b1;
    end
    for (int j = 0; j < h; j++) begin
        img[y + j][x] = 1'b1;
        img[y + j][x + w - 1] = 1'b1;
    end
    if (2 * (w + h) - 4 >= `ZC_MIN_EDGE_LENGTH) begin
        good_rects++;
    end
endtask

// Open outline, never a stripe
task automatic draw_segment(input int x, input int y, input int len);
    for (int i = 0; i < len; i++) begin
        img[y][x + i] = 1'b1;
    end
endtask

task automatic draw_random_frame();
    int kind;
    int w;
    int h;
    int x;
    int y;
    clear_image();
    // First shape sits in the lower left corner of the margin
    w = random_in_range(3, 8);
    h = random_in_range(3, 6);
    draw_rect(lo, y_hi - h + 1, w, h);
    for (int tries = 0; tries < 60; tries++) begin
        kind = random_in_range(0, 3);
        w = (kind == 0) ? random_in_range(3, 16) : random_in_range(3, 10);
        h = (kind == 0) ? 1 : random_in_range(3, 8);
        x = random_in_range(lo, x_hi - w + 1);
        y = random_in_range(lo, y_hi - h + 1);
        if (area_free(x, y, w, h)) begin
            if (kind == 0) begin
                draw_segment(x, y, w);
            end else begin
                draw_rect(x, y, w, h);
            end
        end
    end
endtask

function automatic detect_pkg::detect_result_t predict_result();
    detect_pkg::detect_result_t p;
    p.stripes  = (good_rects > 255) ? 8'd255 : 8'(good_rects);
    p.crossing = (good_rects >= `ZC_MIN_STRIPES);
    return p;
endfunction

`endif

/* test/tb_zebra_crossing.sv */
`default_nettype none

`include "zebra_consts.svh"

module tb_zebra_crossing;

    localparam int clk_period  = 40;
    localparam int npix        = `ZC_IMG_WIDTH * `ZC_IMG_HEIGHT;
    localparam int num_tests   = 10;
    localparam int trace_limit = 2 * npix * 12;

    logic clk = 1'b0;
    logic rst_n;
    logic pix_valid;
    logic pix_bit;
    logic frame_start;
    logic result_valid;
    detect_pkg::detect_result_t result;

    // Verdict of the frame in flight
    detect_pkg::detect_result_t expected;
    logic expect_result;
    int errors = 0;
    int err_mark = 0;
    int tests_run = 0;
    int tests_failed = 0;

    `include "tb_frame_patterns.svh"

    zebra_crossing_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .pix_bit      (pix_bit),
        .frame_start  (frame_start),
        .result_valid (result_valid),
        .result       (result)
    );

    always #(clk_period / 2) clk = ~clk;

    a_no_stray_result: assert property (
        @(posedge clk) disable iff (!rst_n) result_valid |-> expect_result
    ) else begin
        errors = errors + 1;
        $display("%0t: result_valid pulsed with no complete frame pending", $time);
    end

    a_stripes: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(result_valid) |-> (result.stripes == expected.stripes)
    ) else begin
        errors = errors + 1;
        $display("Mismatch at %0t: result.stripes = %0d, expected %0d",
                 $time, result.stripes, expected.stripes);
    end

    a_crossing: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(result_valid) |-> (result.crossing == expected.crossing)
    ) else begin
        errors = errors + 1;
        $display("Mismatch at %0t: result.crossing = %0b, expected %0b",
                 $time, result.crossing, expected.crossing);
    end

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Raster order, first pixel flagged
    task automatic send_frame(input int count);
        for (int i = 0; i < count; i++) begin
            pix_valid   = 1'b1;
            pix_bit     = img[i / img_w][i % img_w];
            frame_start = (i == 0);
            @(posedge clk);
            #2;
        end
        pix_valid   = 1'b0;
        frame_start = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("Test %-18s %s", name, (errors == err_mark) ? "ok" : "errors");
        err_mark = errors;
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        while (!result_valid && cycles < trace_limit) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!result_valid) begin
            errors++;
            $display("%0t: no result within %0d cycles of the frame", $time, trace_limit);
        end
        // Let the checks see the pulse before the pending flag drops
        @(posedge clk);
        #2;
        expect_result = 1'b0;
    endtask

    task automatic run_frame_test(input string name);
        expected = predict_result();
        send_frame(npix);
        expect_result = 1'b1;
        wait_result();
        finish_test(name);
    endtask

    initial begin
        rst_n         = 1'b0;
        pix_valid     = 1'b0;
        pix_bit       = 1'b0;
        frame_start   = 1'b0;
        expect_result = 1'b0;
        expected      = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Half a frame must not produce a verdict
        clear_image();
        draw_rect(4, 4, 6, 6);
        send_frame(npix / 2);
        idle(2 * npix);
        finish_test("idle_after_reset");

        clear_image();
        run_frame_test("blank_frame");

        clear_image();
        draw_rect(3, 3, 6, 4);
        draw_rect(12, 3, 5, 5);
        draw_rect(20, 10, 8, 6);
        run_frame_test("three_rects");

        clear_image();
        draw_rect(4, 4, 10, 6);
        draw_rect(18, 12, 9, 7);
        run_frame_test("two_rects");

        // Short outlines, the exact threshold and open segments
        clear_image();
        draw_rect(2, 2, 3, 3);
        draw_rect(8, 2, 4, 3);
        draw_rect(15, 2, 3, 4);
        draw_rect(21, 2, 5, 3);
        draw_segment(2, 9, 14);
        draw_segment(5, 14, 20);
        draw_segment(10, 21, 20);
        run_frame_test("small_and_open");

        repeat (4) begin
            draw_random_frame();
            run_frame_test("random_frame");
        end

        // Second frame lands while the first is still traced
        clear_image();
        draw_rect(5, 5, 8, 5);
        expected = predict_result();
        send_frame(npix);
        expect_result = 1'b1;
        clear_image();
        draw_rect(3, 3, 6, 4);
        draw_rect(12, 3, 5, 5);
        draw_rect(20, 10, 8, 6);
        draw_rect(4, 12, 10, 3);
        send_frame(npix);
        wait_result();
        idle(2 * npix);
        finish_test("overlap_dropped");

        $display("Tests run: %0d, tests with errors: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(num_tests * trace_limit * clk_period);
        $display("Watchdog expired before all tests finished");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
+incdir+test
src/img_pkg.sv
src/detect_pkg.sv
src/edge_frame_buffer.sv
src/contour_tracer.sv
src/crossing_verdict.sv
src/zebra_crossing_top.sv
test/tb_zebra_crossing.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_zebra_crossing -f build.f

output=$(./obj_dir/Vtb_zebra_crossing)
echo "$output"

if echo "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1
